/* list.f */
verilog/eth_tx_pkg.sv
verilog/crc32.sv
verilog/tx_frame_buffer.sv
verilog/tx_mac.sv
verilog/eth_tx_top.sv
testbench/eth_tx_checker.sv
testbench/tb_eth_tx.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary -f list.f --top-module tb_eth_tx -o sim_eth_tx > build.log 2>&1 \
    && ./obj_dir/sim_eth_tx > sim.log 2>&1 \
    || { echo "Build or simulation failed"; exit 1; }

grep -q "Errors found" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "No errors" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"

/* testbench/eth_tx_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module eth_tx_checker
    import eth_tx_pkg::*;
(
    input wire              i_clk,
    input wire              i_reset,
    input wire              i_phy_tx_ready,
    input wire xgmii_data_t i_txd,
    input wire xgmii_ctl_t  i_txc,
    input wire              i_s_tvalid,
    input wire              i_s_tready,
    input wire              i_s_tlast
);

    // Expected bytes of all pending frames, FCS included
    logic [7:0] exp_bytes [$];
    int         exp_len [$];
    int         exp_id [$];
    logic [7:0] new_bytes [$];
    logic [7:0] got_bytes [$];

    int   pass_cnt = 0;
    int   fail_cnt = 0;
    int   err_cnt = 0;
    int   frames_done = 0;
    int   lasts_in = 0;
    int   starts = 0;
    int   gap_cnt = 0;
    int   idle_cycles = 0;
    logic in_frame = 1'b0;
    logic cur_err = 1'b0;
    logic timed_out = 1'b0;
    logic saw_tready_low = 1'b0;

    task automatic add_byte(input logic [7:0] b);
        new_bytes.push_back(b);
    endtask

    // Pads, appends the FCS and queues the frame
    task automatic end_frame(input int id);
        logic [31:0] r;
        int          n;
        while (new_bytes.size() < MIN_FRAME_BYTES) begin
            new_bytes.push_back(8'h00);
        end
        r = 32'hFFFFFFFF;
        foreach (new_bytes[i]) begin
            r = r ^ {24'h000000, new_bytes[i]};
            for (int b = 0; b < 8; b++) begin
                r = r[0] ? ((r >> 1) ^ 32'hEDB88320) : (r >> 1);
            end
        end
        r = ~r;
        n = new_bytes.size();
        foreach (new_bytes[i]) begin
            exp_bytes.push_back(new_bytes[i]);
        end
        for (int k = 0; k < 4; k++) begin
            exp_bytes.push_back(r[k*8 +: 8]);
        end
        exp_len.push_back(n + 4);
        exp_id.push_back(id);
        new_bytes.delete();
    endtask

    task automatic note_error();
        err_cnt++;
        cur_err = 1'b1;
    endtask

    // A burst larger than the buffer must have met a full buffer
    task automatic check_backpressure();
        if (!saw_tready_low) begin
            $display("o_s_tready never went low while a word was waiting");
            err_cnt++;
        end
    endtask

    task automatic finish_frame();
        int         id;
        int         n;
        logic [7:0] e;
        logic       shown;
        shown = 1'b0;
        if (exp_id.size() == 0) begin
            $display("Frame seen on the XGMII with no expected frame pending");
            err_cnt++;
            fail_cnt++;
        end else begin
            id = exp_id.pop_front();
            n = exp_len.pop_front();
            if (got_bytes.size() != n) begin
                $display("Test %0d has %0d bytes before the terminate, expected %0d",
                         id, got_bytes.size(), n);
                note_error();
            end
            for (int i = 0; i < n; i++) begin
                e = exp_bytes.pop_front();
                if (!shown && i < got_bytes.size() && got_bytes[i] != e) begin
                    $display("ERROR test %0d o_xgmii_txd byte %0d expected %h got %h",
                             id, i, e, got_bytes[i]);
                    note_error();
                    shown = 1'b1;
                end
            end
            if (cur_err) begin
                fail_cnt++;
                $display("FAIL test %0d", id);
            end else begin
                pass_cnt++;
                $display("PASS test %0d (%0d bytes with FCS)", id, n);
            end
        end
        frames_done++;
        idle_cycles = 0;
    endtask

    always @(posedge i_clk) begin : monitor
        logic [7:0] b;
        logic       term_seen;
        logic       bad_idle;
        int         cur_id;
        if (!i_reset) begin
            cur_id = (exp_id.size() > 0) ? exp_id[0] : -1;
            if (i_phy_tx_ready && !in_frame) begin
                if (i_txc[0] && i_txd[7:0] == RS_START) begin
                    cur_err = 1'b0;
                    got_bytes.delete();
                    if (starts >= lasts_in) begin
                        $display("Test %0d started before its last word was written", cur_id);
                        note_error();
                    end
                    if (frames_done > 0 && gap_cnt < IPG_BYTES) begin
                        $display("ERROR test %0d o_xgmii_txd idle gap expected >= %h got %h",
                                 cur_id, IPG_BYTES, gap_cnt);
                        note_error();
                    end
                    if (i_txd != 64'hD5555555555555FB) begin
                        $display("ERROR test %0d o_xgmii_txd expected %h got %h",
                                 cur_id, 64'hD5555555555555FB, i_txd);
                        note_error();
                    end
                    if (i_txc != 8'h01) begin
                        $display("ERROR test %0d o_xgmii_txc expected %h got %h",
                                 cur_id, 8'h01, i_txc);
                        note_error();
                    end
                    starts++;
                    in_frame = 1'b1;
                end else if (i_txd == {8{RS_IDLE}} && i_txc == 8'hFF) begin
                    gap_cnt += 8;
                end else begin
                    $display("ERROR o_xgmii_txd outside a frame expected %h got %h",
                             {8{RS_IDLE}}, i_txd);
                    err_cnt++;
                end
            end else if (i_phy_tx_ready) begin
                term_seen = 1'b0;
                bad_idle = 1'b0;
                for (int lane = 0; lane < 8; lane++) begin
                    b = i_txd[lane*8 +: 8];
                    if (term_seen) begin
                        if (i_txc[lane] && b == RS_IDLE) begin
                            gap_cnt++;
                        end else begin
                            bad_idle = 1'b1;
                        end
                    end else if (!i_txc[lane]) begin
                        got_bytes.push_back(b);
                    end else if (b == RS_TERM) begin
                        term_seen = 1'b1;
                        gap_cnt = 0;
                    end else begin
                        $display("Test %0d has control character %h inside the frame",
                                 cur_id, b);
                        note_error();
                    end
                end
                if (bad_idle) begin
                    $display("ERROR test %0d o_xgmii_txd after terminate expected %h got %h",
                             cur_id, {8{RS_IDLE}}, i_txd);
                    note_error();
                end
                if (term_seen) begin
                    in_frame = 1'b0;
                    finish_frame();
                end
            end
            if (i_s_tvalid && !i_s_tready) begin
                saw_tready_low = 1'b1;
            end
            if (i_s_tvalid && i_s_tready && i_s_tlast) begin
                lasts_in++;
            end
            if (exp_id.size() > 0 && !timed_out) begin
                idle_cycles++;
                if (idle_cycles >= 5000) begin
                    $display("Timeout waiting for the end of test %0d on the XGMII", exp_id[0]);
                    timed_out = 1'b1;
                    err_cnt++;
                    fail_cnt++;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/eth_tx_trace.txt */
# test_id byte_len payload_seed(hex) user_gap phy_stall
# Lengths 60 to 67 cover every residue of length modulo 8
1 60 00000011 0 0
2 61 00000022 0 0
3 62 00000033 0 0
4 63 00000044 0 0
5 64 00000055 0 0
6 65 00000066 0 0
7 66 00000077 0 0
8 67 00000088 0 0
9 1 00000099 0 0
10 17 000000aa 0 0
11 45 000000bb 1 0
12 59 000000cc 0 1
13 200 000000dd 1 0
14 333 000000ee 0 1
15 1500 00000101 0 1
16 1500 00000202 0 1
17 1500 00000303 0 1
18 1499 00000404 1 1
19 71 00000505 1 1
20 100 00000606 0 0

/* testbench/tb_eth_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_eth_tx
    import eth_tx_pkg::*;
();

    logic        i_clk;
    logic        i_reset;
    logic        phy_tx_ready;
    xgmii_data_t s_tdata;
    keep_t       s_tkeep;
    logic        s_tvalid;
    logic        s_tlast;
    logic        s_tready;
    xgmii_data_t xgmii_txd;
    xgmii_ctl_t  xgmii_txc;

    integer seed;
    integer gap_seed;
    integer stall_seed;
    int     stall_left;
    logic   stall_en;
    logic   drive_err;
    int     n_frames;

    eth_tx_top u_dut (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_phy_tx_ready (phy_tx_ready),
        .i_s_tdata      (s_tdata),
        .i_s_tkeep      (s_tkeep),
        .i_s_tvalid     (s_tvalid),
        .i_s_tlast      (s_tlast),
        .o_s_tready     (s_tready),
        .o_xgmii_txd    (xgmii_txd),
        .o_xgmii_txc    (xgmii_txc)
    );

    eth_tx_checker u_chk (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_phy_tx_ready (phy_tx_ready),
        .i_txd          (xgmii_txd),
        .i_txc          (xgmii_txc),
        .i_s_tvalid     (s_tvalid),
        .i_s_tready     (s_tready),
        .i_s_tlast      (s_tlast)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    // Random PHY stall spans of 1 to 8 cycles
    initial begin
        integer r;
        stall_left = 0;
        forever begin
            @(negedge i_clk);
            r = $random(stall_seed);
            if (stall_left > 0) begin
                stall_left--;
                phy_tx_ready = 1'b0;
            end else if (stall_en && (r & 3) == 0) begin
                stall_left = (r >>> 4) & 7;
                phy_tx_ready = 1'b0;
            end else begin
                phy_tx_ready = 1'b1;
            end
        end
    end

    task automatic send_frame(input int id, input int len, input int pseed,
                              input int gap, input int stall);
        integer      s;
        integer      r;
        logic [7:0]  bytes [$];
        int          nwords;
        int          t;
        xgmii_data_t d;
        keep_t       k;
        s = seed ^ pseed;
        for (int i = 0; i < len; i++) begin
            r = $random(s);
            bytes.push_back(r[7:0]);
            u_chk.add_byte(r[7:0]);
        end
        u_chk.end_frame(id);
        n_frames++;
        stall_en = (stall != 0);
        nwords = (len + 7) / 8;
        for (int w = 0; w < nwords; w++) begin
            d = '0;
            k = '0;
            for (int l = 0; l < 8; l++) begin
                if (w * 8 + l < len) begin
                    d[l*8 +: 8] = bytes[w*8 + l];
                    k[l] = 1'b1;
                end
            end
            r = $random(gap_seed);
            if (gap != 0 && (r & 3) == 0) begin
                s_tvalid = 1'b0;
                repeat (1 + ((r >>> 4) & 3)) @(negedge i_clk);
            end
            s_tdata = d;
            s_tkeep = k;
            s_tlast = (w == nwords - 1);
            s_tvalid = 1'b1;
            t = 0;
            while (!s_tready && t < 5000) begin
                @(negedge i_clk);
                t++;
            end
            if (t >= 5000) begin
                $display("Timeout waiting for o_s_tready in test %0d", id);
                drive_err = 1'b1;
                s_tvalid = 1'b0;
                return;
            end
            // Ready is stable here, so the word moves on the next rising edge
            @(negedge i_clk);
        end
        s_tvalid = 1'b0;
        s_tlast = 1'b0;
    endtask

    initial begin
        int    fd;
        int    id;
        int    len;
        int    pseed;
        int    gap;
        int    stall;
        int    guard;
        int    last_done;
        string line;
        i_reset = 1'b1;
        phy_tx_ready = 1'b1;
        s_tdata = '0;
        s_tkeep = '0;
        s_tvalid = 1'b0;
        s_tlast = 1'b0;
        seed = 32'h27d7a81b;
        gap_seed = seed ^ 32'h0000_0101;
        stall_seed = seed ^ 32'h0000_0202;
        stall_en = 1'b0;
        drive_err = 1'b0;
        n_frames = 0;
        repeat (10) @(posedge i_clk);
        @(negedge i_clk);
        i_reset = 1'b0;
        repeat (2) @(negedge i_clk);

        fd = $fopen("testbench/eth_tx_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file");
            drive_err = 1'b1;
        end else begin
            while (!drive_err && $fgets(line, fd) != 0) begin
                if (line.len() > 0 && line.getc(0) != "#") begin
                    if ($sscanf(line, "%d %d %h %d %d", id, len, pseed, gap, stall) == 5) begin
                        send_frame(id, len, pseed, gap, stall);
                    end
                end
            end
            $fclose(fd);
        end

        // Wait for the XGMII side, restarting the bound on each finished frame
        guard = 0;
        last_done = u_chk.frames_done;
        while (u_chk.frames_done < n_frames && !u_chk.timed_out && guard < 5000) begin
            @(negedge i_clk);
            if (u_chk.frames_done != last_done) begin
                last_done = u_chk.frames_done;
                guard = 0;
            end else begin
                guard++;
            end
        end
        if (guard >= 5000) begin
            $display("Timeout waiting for the remaining frames on the XGMII");
            drive_err = 1'b1;
        end
        u_chk.check_backpressure();

        $display("Tests passed %0d, failed %0d, errors %0d",
                 u_chk.pass_cnt, u_chk.fail_cnt, u_chk.err_cnt);
        if (drive_err || u_chk.err_cnt > 0 || u_chk.fail_cnt > 0) begin
            $display("Errors found");
        end else begin
            $display("No errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/crc32.sv */
`timescale 1ns/1ps
`default_nettype none

module crc32
    import eth_tx_pkg::*;
(
    input  wire              i_clk,
    input  wire              i_reset,
    input  wire              i_clear,
    input  wire xgmii_data_t i_data,
    input  wire keep_t       i_lane_en,
    output crc_t             o_crc
);

    crc_t crc_reg;
    crc_t crc_next;

    // Lanes folded in order, lane 0 first
    always_comb begin
        crc_next = crc_reg;
        for (int lane = 0; lane < 8; lane++) begin
            if (i_lane_en[lane]) begin
                crc_next = crc_next ^ {24'h000000, i_data[lane*8 +: 8]};
                for (int b = 0; b < 8; b++) begin
                    if (crc_next[0]) begin
                        crc_next = (crc_next >> 1) ^ CRC_POLY;
                    end else begin
                        crc_next = crc_next >> 1;
                    end
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset || i_clear) begin
            crc_reg <= '1;
        end else begin
            crc_reg <= crc_next;
        end
    end

    // FCS is the complement of the register
    assign o_crc = ~crc_reg;

endmodule

`default_nettype wire

/* verilog/eth_tx_pkg.sv */
`default_nettype none

package eth_tx_pkg;

    typedef logic [63:0] xgmii_data_t;
    typedef logic [7:0]  xgmii_ctl_t;
    typedef logic [7:0]  keep_t;
    typedef logic [31:0] crc_t;

    // XGMII control characters
    localparam logic [7:0] RS_IDLE  = 8'h07;
    localparam logic [7:0] RS_START = 8'hFB;
    localparam logic [7:0] RS_TERM  = 8'hFD;
    localparam logic [7:0] RS_ERROR = 8'hFE;

    localparam logic [7:0] MAC_PRE = 8'h55;
    localparam logic [7:0] MAC_SFD = 8'hD5;

    localparam xgmii_data_t IDLE_WORD  = {8{RS_IDLE}};
    localparam xgmii_data_t ERROR_WORD = {8{RS_ERROR}};
    // First preamble byte replaced by the start character
    localparam xgmii_data_t START_WORD = {MAC_SFD, {6{MAC_PRE}}, RS_START};

    // Frame size without FCS, gap in bytes
    localparam int MIN_FRAME_BYTES = 60;
    localparam int IPG_BYTES       = 12;

    localparam int BUF_DEPTH_WORDS = 256;
    localparam int BUF_ADDR_BITS   = 8;

    // Reflected IEEE 802.3 polynomial
    localparam crc_t CRC_POLY = 32'hEDB88320;

    typedef enum logic [2:0] {IDLE, DATA, PAD, TERM, IPG} tx_state_t;

endpackage

`default_nettype wire

/* verilog/eth_tx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module eth_tx_top
    import eth_tx_pkg::*;
(
    input  wire              i_clk,
    input  wire              i_reset,
    input  wire              i_phy_tx_ready,
    input  wire xgmii_data_t i_s_tdata,
    input  wire keep_t       i_s_tkeep,
    input  wire              i_s_tvalid,
    input  wire              i_s_tlast,
    output logic             o_s_tready,
    output xgmii_data_t      o_xgmii_txd,
    output xgmii_ctl_t       o_xgmii_txc
);

    xgmii_data_t buf_tdata;
    keep_t       buf_tkeep;
    logic        buf_tvalid;
    logic        buf_tlast;
    logic        buf_tready;

    tx_frame_buffer u_buffer (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_s_tdata  (i_s_tdata),
        .i_s_tkeep  (i_s_tkeep),
        .i_s_tvalid (i_s_tvalid),
        .i_s_tlast  (i_s_tlast),
        .o_s_tready (o_s_tready),
        .o_m_tdata  (buf_tdata),
        .o_m_tkeep  (buf_tkeep),
        .o_m_tvalid (buf_tvalid),
        .o_m_tlast  (buf_tlast),
        .i_m_tready (buf_tready)
    );

    tx_mac u_mac (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_phy_tx_ready (i_phy_tx_ready),
        .i_tdata        (buf_tdata),
        .i_tkeep        (buf_tkeep),
        .i_tvalid       (buf_tvalid),
        .i_tlast        (buf_tlast),
        .o_tready       (buf_tready),
        .o_xgmii_txd    (o_xgmii_txd),
        .o_xgmii_txc    (o_xgmii_txc)
    );

endmodule

`default_nettype wire

/* verilog/tx_frame_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_frame_buffer
    import eth_tx_pkg::*;
(
    input  wire              i_clk,
    input  wire              i_reset,
    input  wire xgmii_data_t i_s_tdata,
    input  wire keep_t       i_s_tkeep,
    input  wire              i_s_tvalid,
    input  wire              i_s_tlast,
    output logic             o_s_tready,
    output xgmii_data_t      o_m_tdata,
    output keep_t            o_m_tkeep,
    output logic             o_m_tvalid,
    output logic             o_m_tlast,
    input  wire              i_m_tready
);

    xgmii_data_t mem_data [BUF_DEPTH_WORDS];
    keep_t       mem_keep [BUF_DEPTH_WORDS];
    logic        mem_last [BUF_DEPTH_WORDS];

    // Extra top bit tells full from empty
    logic [BUF_ADDR_BITS:0] wr_ptr;
    logic [BUF_ADDR_BITS:0] rd_ptr;
    logic [BUF_ADDR_BITS:0] frame_cnt;
    logic                   ready_en;
    logic                   full;
    logic                   wr_en;
    logic                   rd_en;

    assign full = (wr_ptr[BUF_ADDR_BITS] != rd_ptr[BUF_ADDR_BITS]) &&
                  (wr_ptr[BUF_ADDR_BITS-1:0] == rd_ptr[BUF_ADDR_BITS-1:0]);

    assign o_s_tready = ready_en && !full;
    assign wr_en      = i_s_tvalid && o_s_tready;

    // A frame stays counted until its last word is read, so valid
    // holds through the whole readout
    assign o_m_tvalid = frame_cnt != '0;
    assign rd_en      = o_m_tvalid && i_m_tready;

    assign o_m_tdata = mem_data[rd_ptr[BUF_ADDR_BITS-1:0]];
    assign o_m_tkeep = mem_keep[rd_ptr[BUF_ADDR_BITS-1:0]];
    assign o_m_tlast = mem_last[rd_ptr[BUF_ADDR_BITS-1:0]];

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            mem_data[wr_ptr[BUF_ADDR_BITS-1:0]] <= i_s_tdata;
            mem_keep[wr_ptr[BUF_ADDR_BITS-1:0]] <= i_s_tkeep;
            mem_last[wr_ptr[BUF_ADDR_BITS-1:0]] <= i_s_tlast;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            frame_cnt <= '0;
            ready_en  <= 1'b0;
        end else begin
            ready_en <= 1'b1;
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en && i_s_tlast, rd_en && o_m_tlast})
                2'b10:   frame_cnt <= frame_cnt + 1'b1;
                2'b01:   frame_cnt <= frame_cnt - 1'b1;
                default: frame_cnt <= frame_cnt;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/tx_mac.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_mac
    import eth_tx_pkg::*;
(
    input  wire              i_clk,
    input  wire              i_reset,
    input  wire              i_phy_tx_ready,
    input  wire xgmii_data_t i_tdata,
    input  wire keep_t       i_tkeep,
    input  wire              i_tvalid,
    input  wire              i_tlast,
    output logic             o_tready,
    output xgmii_data_t      o_xgmii_txd,
    output xgmii_ctl_t       o_xgmii_txc
);

    tx_state_t   state;
    tx_state_t   state_next;

    // Word on the output, keep includes pad lanes
    xgmii_data_t data_q;
    keep_t       keep_q;
    logic        last_q;
    // Bytes through data_q, saturates once the minimum is reached
    logic [6:0]  byte_cnt;
    logic [4:0]  ipg_cnt;

    xgmii_data_t crc_data;
    keep_t       crc_lane_en;
    logic        crc_clear;
    crc_t        crc_value;

    logic        take_input;
    logic        advance_pad;
    logic        pad_needed;
    logic        final_word;
    keep_t       next_pad;
    keep_t       next_keep;
    xgmii_data_t next_data;

    logic [3:0]   last_bytes;
    logic         two_words;
    logic [4:0]   ipg_init;
    logic [127:0] term_tail;
    logic [127:0] term_txd;
    logic [15:0]  term_txc;

    function automatic logic [3:0] popcount(keep_t k);
        logic [3:0] c;
        c = '0;
        for (int i = 0; i < 8; i++) begin
            c = c + 4'(k[i]);
        end
        return c;
    endfunction

    // Lanes still short of the minimum frame size
    function automatic keep_t fill_mask(logic [6:0] done);
        keep_t m;
        for (int i = 0; i < 8; i++) begin
            m[i] = (int'(done) + i) < MIN_FRAME_BYTES;
        end
        return m;
    endfunction

    function automatic xgmii_data_t mask_lanes(xgmii_data_t d, keep_t k);
        xgmii_data_t r;
        for (int i = 0; i < 8; i++) begin
            r[i*8 +: 8] = k[i] ? d[i*8 +: 8] : 8'h00;
        end
        return r;
    endfunction

    assign pad_needed = byte_cnt < MIN_FRAME_BYTES;
    assign next_pad   = fill_mask(byte_cnt);

    // Store-and-forward keeps tvalid high for the rest of a frame
    assign take_input = i_phy_tx_ready && i_tvalid &&
                        (state == IDLE || (state == DATA && !last_q));
    assign o_tready   = take_input;

    assign advance_pad = i_phy_tx_ready && (state == DATA || state == PAD) &&
                         last_q && pad_needed;
    assign final_word  = (state == DATA || state == PAD) && last_q && !pad_needed;

    assign next_data = take_input ? mask_lanes(i_tdata, i_tkeep) : '0;
    assign next_keep = take_input ? (i_tkeep | next_pad) : next_pad;

    // Each word enters the CRC one cycle before it goes out
    assign crc_data    = next_data;
    assign crc_lane_en = (take_input || advance_pad) ? next_keep : '0;
    assign crc_clear   = state == IPG;

    crc32 u_crc (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_clear   (crc_clear),
        .i_data    (crc_data),
        .i_lane_en (crc_lane_en),
        .o_crc     (crc_value)
    );

    // Data, FCS LSB first, terminate, then idles
    assign last_bytes = popcount(keep_q);
    assign term_tail  = {{11{RS_IDLE}}, RS_TERM, crc_value};
    assign term_txd   = (term_tail << {last_bytes, 3'b000}) | {64'h0, data_q};
    assign term_txc   = 16'hFFF0 << last_bytes;
    assign two_words  = last_bytes >= 4'd4;
    assign ipg_init   = two_words ? (5'd11 - 5'(last_bytes)) : (5'd3 - 5'(last_bytes));

    always_comb begin
        state_next  = state;
        o_xgmii_txd = IDLE_WORD;
        o_xgmii_txc = '1;
        case (state)
            IDLE: begin
                if (i_tvalid) begin
                    state_next  = DATA;
                    o_xgmii_txd = START_WORD;
                    o_xgmii_txc = 8'h01;
                end
            end
            DATA, PAD: begin
                if (final_word) begin
                    o_xgmii_txd = term_txd[63:0];
                    o_xgmii_txc = term_txc[7:0];
                    state_next  = two_words ? TERM : IPG;
                end else begin
                    o_xgmii_txd = data_q;
                    o_xgmii_txc = '0;
                    if (last_q) begin
                        state_next = PAD;
                    end
                end
            end
            TERM: begin
                o_xgmii_txd = term_txd[127:64];
                o_xgmii_txc = term_txc[15:8];
                state_next  = IPG;
            end
            IPG: begin
                if (ipg_cnt + 5'd8 >= IPG_BYTES) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
        // Word is discarded downstream while the PHY is not ready
        if (!i_phy_tx_ready) begin
            o_xgmii_txd = ERROR_WORD;
            o_xgmii_txc = '1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state    <= IDLE;
            last_q   <= 1'b0;
            byte_cnt <= '0;
            ipg_cnt  <= '0;
        end else if (i_phy_tx_ready) begin
            state <= state_next;
            if (take_input) begin
                last_q <= i_tlast;
            end
            if (state == IPG) begin
                byte_cnt <= '0;
            end else if ((take_input || advance_pad) && pad_needed) begin
                byte_cnt <= byte_cnt + 7'(popcount(next_keep));
            end
            if (final_word) begin
                ipg_cnt <= ipg_init;
            end else if (state == IPG) begin
                ipg_cnt <= ipg_cnt + 5'd8;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_phy_tx_ready && (take_input || advance_pad)) begin
            data_q <= next_data;
            keep_q <= next_keep;
        end
    end

endmodule

`default_nettype wire
